//--- flist.f
verilog/board_pkg.sv
verilog/uart_rx.sv
verilog/intr_ctrl.sv
verilog/cpu.sv
verilog/rom.sv
verilog/mother_board.sv
sim/board_props.sv
sim/tb_int_uart_rx.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_int_uart_rx -Mdir obj_dir -f flist.f

status=0
./obj_dir/Vtb_int_uart_rx > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Simulation finished: FAIL" sim.log; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"

//--- sim/board_props.sv
`timescale 1ns/1ps

module board_props (
  input logic clk,
  input logic rst_n,
  input logic out_valid,
  input logic halted,
  input logic trap_take,
  input logic iret
);

  logic in_trap;  // handler entered and not yet left

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      in_trap <= 1'b0;
    end else if (trap_take) begin
      in_trap <= 1'b1;
    end else if (iret) begin
      in_trap <= 1'b0;
    end
  end

  out_one_cycle: assert property (@(posedge clk) disable iff (!rst_n) out_valid |=> !out_valid)
    else $error("out_valid held for two cycles");

  no_nested_trap: assert property (@(posedge clk) disable iff (!rst_n) trap_take |-> !in_trap)
    else $error("trap taken while a handler is active");

  halt_sticky: assert property (@(posedge clk) disable iff (!rst_n) halted |=> halted)
    else $error("halted fell without reset");

endmodule

bind cpu board_props props_i (
  .clk       (clk),
  .rst_n     (rst_n),
  .out_valid (out_valid),
  .halted    (halted),
  .trap_take (trap_take),
  .iret      (iret)
);

//--- sim/tb_int_uart_rx.sv
`timescale 1ns/1ps

module tb_int_uart_rx;
  import board_pkg::*;

  typedef enum logic [1:0] {PRG_NONE, PRG_ACK_ON, PRG_ACK_OFF, PRG_INTR_OFF} prog_e;

  typedef struct packed {
    logic [7:0] rx_byte;
    logic       rnd;       // byte drawn from $urandom
    logic       bad_stop;
    prog_e      prog;
    logic [1:0] exp_strobes;
    logic [7:0] exp_data;
    logic       exp_irq;
  } row_t;

  localparam int NROWS        = 9;
  localparam int HANDLER      = 17;     // odd, so the vector register also sets the enable
  localparam int MARKER_ADDR  = 64;
  localparam int MARKER       = 'h5A5;  // never a received byte
  localparam int HALT_TIMEOUT = 400;
  localparam int SETTLE       = 4 * BAUD_DIV;

  logic            clk = 1'b0;
  logic            rst_n, uart_rx, run, prog_we;
  logic [AW-1:0]   prog_addr;
  instr_t          prog_data;
  logic            out_valid, irq_pending, halted;
  logic [XLEN-1:0] out_data;
  logic [XLEN-1:0] last_out;
  row_t            rows [NROWS];
  int              strobes = 0;
  int              markers = 0;
  int              errors, n_pass, n_fail;

  mother_board dut_i (
    .clk(clk), .rst_n(rst_n), .uart_rx(uart_rx), .run(run), .prog_we(prog_we),
    .prog_addr(prog_addr), .prog_data(prog_data), .out_valid(out_valid),
    .out_data(out_data), .irq_pending(irq_pending), .halted(halted)
  );

  always #4 clk = ~clk;

  always @(negedge clk) begin
    if (out_valid) begin
      strobes  = strobes + 1;
      last_out = out_data;
      if (out_data == XLEN'(MARKER)) markers = markers + 1;
    end
  end

  function automatic instr_t enc(op_e op, int rd, int rs1, int imm);
    instr_t w;
    w        = '0;
    w.opcode = op;
    w.rd     = 4'(rd);
    w.rs1    = 4'(rs1);
    w.imm    = 12'(imm);
    return w;
  endfunction

  function automatic instr_t prog_word(int addr, prog_e prog);
    instr_t nop;
    nop = instr_t'(32'h0000_000f);  // opcode 15 is unused
    case (addr)
      0:               return enc(OP_LI, 1, 0, HANDLER);
      1:               return enc(OP_LI, 15, 0, MARKER_ADDR);
      2:               return (prog == PRG_NONE) ? nop : enc(OP_INTR, 0, 1, 2);
      3: begin
        if (prog == PRG_NONE) return nop;
        return enc(OP_INTR, 0, (prog == PRG_INTR_OFF) ? 15 : 1, 1);  // r15 has bit 0 clear
      end
      4:               return enc(OP_HALT, 0, 0, 0);
      HANDLER:         return enc(OP_IN, 3, 0, IO_RX_DATA);
      HANDLER + 1:     return enc(OP_OUT, 0, 3, 0);
      HANDLER + 2:     return enc(OP_LI, 4, 0, (prog == PRG_ACK_OFF) ? 0 : 1);
      HANDLER + 3:     return enc(OP_INTR, 0, 4, 0);
      HANDLER + 4:     return enc(OP_IRET, 0, 0, 0);
      MARKER_ADDR:     return enc(OP_LI, 14, 0, MARKER);
      MARKER_ADDR + 1: return enc(OP_OUT, 0, 14, 0);
      MARKER_ADDR + 2: return enc(OP_HALT, 0, 0, 0);
      default:         return enc(OP_JMP, 0, 15, 0);  // stray fetch ends in the marker
    endcase
  endfunction

  function automatic row_t make_row(logic [7:0] b, logic rnd, logic bad, prog_e p,
                                    logic [1:0] n, logic [7:0] d, logic irq);
    return {b, rnd, bad, p, n, d, irq};
  endfunction

  task automatic reset_board();
    @(posedge clk);
    rst_n   <= 1'b0;
    run     <= 1'b0;
    prog_we <= 1'b0;
    uart_rx <= 1'b1;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
  endtask

  task automatic load_program(prog_e prog);
    for (int a = 0; a < ROM_DEPTH; a++) begin
      @(posedge clk);
      prog_we   <= 1'b1;
      prog_addr <= AW'(a);
      prog_data <= prog_word(a, prog);
    end
    @(posedge clk);
    prog_we <= 1'b0;
  endtask

  task automatic send_frame(logic [7:0] data, logic stop_bit);
    logic [9:0] bits;
    bits = {stop_bit, data, 1'b0};  // start bit goes first, lsb first
    for (int i = 0; i < 10; i++) begin
      @(posedge clk);
      uart_rx <= bits[i];
      repeat (BAUD_DIV - 1) @(posedge clk);
    end
    @(posedge clk);
    uart_rx <= 1'b1;
  endtask

  task automatic wait_halted(output logic ok);
    int n;
    n = 0;
    while (!halted && n < HALT_TIMEOUT) begin
      @(posedge clk);
      n++;
    end
    ok = halted;
  endtask

  task automatic check_value(string what, int expected, int actual);
    assert (expected == actual) else begin
      $display("Error: time %0t, %s expected %0h, got %0h", $time, what, expected, actual);
      errors++;
    end
  endtask

  initial begin
    row_t       r;
    logic [7:0] data;
    logic       ok;
    int         s0, m0;
    rst_n     = 1'b0;
    uart_rx   = 1'b1;
    run       = 1'b0;
    prog_we   = 1'b0;
    prog_addr = '0;
    prog_data = '0;
    n_pass    = 0;
    n_fail    = 0;
    void'($urandom(68713));
    rows[0] = make_row(8'h3C, 1'b0, 1'b0, PRG_NONE,     2'd0, 8'h00, 1'b1);
    rows[1] = make_row(8'h8F, 1'b0, 1'b0, PRG_ACK_ON,   2'd1, 8'h8F, 1'b0);
    rows[2] = make_row(8'h5A, 1'b0, 1'b0, PRG_ACK_OFF,  2'd1, 8'h5A, 1'b1);
    rows[3] = make_row(8'hC3, 1'b0, 1'b0, PRG_INTR_OFF, 2'd0, 8'h00, 1'b1);
    for (int i = 4; i < 8; i++) begin
      rows[i] = make_row(8'h00, 1'b1, 1'b0, PRG_ACK_ON, 2'd1, 8'h00, 1'b0);
    end
    rows[8] = make_row(8'hA5, 1'b0, 1'b1, PRG_ACK_ON,   2'd0, 8'h00, 1'b0);  // stop bit low

    for (int i = 0; i < NROWS; i++) begin
      r      = rows[i];
      data   = r.rnd ? 8'($urandom) : r.rx_byte;
      errors = 0;
      reset_board();
      load_program(r.prog);
      s0 = strobes;
      m0 = markers;
      @(posedge clk);
      run <= 1'b1;
      send_frame(data, !r.bad_stop);
      wait_halted(ok);
      assert (ok) else begin
        $display("row %0d: halted never came within %0d cycles", i, HALT_TIMEOUT);
        errors++;
      end
      repeat (SETTLE) @(posedge clk);  // room for the handler to finish
      check_value("out strobes", int'(r.exp_strobes), strobes - s0);
      if (r.exp_strobes != 2'd0) begin
        check_value("out_data", r.rnd ? int'(data) : int'(r.exp_data), int'(last_out));
      end
      check_value("irq_pending", int'(r.exp_irq), int'(irq_pending));
      check_value("halted", 1, int'(halted));
      check_value("marker strobes", 0, markers - m0);
      if (errors == 0) n_pass++;
      else n_fail++;
      $display("row %0d %s byte %02h strobes %0d irq %0b: %s", i, r.prog.name(), data,
               strobes - s0, irq_pending, (errors == 0) ? "ok" : "failed");
    end

    $display("rows passed %0d, failed %0d", n_pass, n_fail);
    if (n_fail == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

//--- verilog/board_pkg.sv
package board_pkg;

  localparam int XLEN      = 32;  // register width
  localparam int NREGS     = 16;  // register count
  localparam int AW        = 8;   // program address width
  localparam int ROM_DEPTH = 256; // program words

  localparam int BAUD_DIV  = 16;  // clocks per serial bit
  localparam int BAUD_CW   = $clog2(BAUD_DIV);

  localparam int IO_IRR     = 0;  // io address of the request flag
  localparam int IO_RX_DATA = 1;  // io address of the received byte

  typedef enum logic [3:0] {
    OP_LI   = 4'd0,   // rd = imm
    OP_ADDI = 4'd1,   // rd = rs1 + imm
    OP_JMP  = 4'd3,   // pc = rs1
    OP_IN   = 4'd6,   // rd = io(imm)
    OP_OUT  = 4'd7,   // out port = rs1
    OP_INTR = 4'd8,   // intr(imm) = rs1
    OP_IRET = 4'd9,
    OP_HALT = 4'd10
  } op_e;

  // interrupt controller command selector, taken from imm of OP_INTR
  typedef enum logic [1:0] {
    INTR_ACK = 2'd0,
    INTR_EN  = 2'd1,
    INTR_VEC = 2'd2
  } intr_sel_e;

  typedef struct packed {
    logic [11:0] imm;
    logic [3:0]  rs2;
    logic [3:0]  rs1;
    logic [3:0]  rd;
    logic [3:0]  opt;    // reserved
    op_e         opcode;
  } instr_t;

  typedef struct packed {
    logic          valid;
    intr_sel_e     sel;
    logic [AW-1:0] value;
  } intr_cmd_t;

endpackage

//--- verilog/cpu.sv
`timescale 1ns/1ps

module cpu (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       run,
  input  logic                       uart_rx,
  output logic [board_pkg::AW-1:0]   fetch_addr,
  input  board_pkg::instr_t          instr,
  output logic                       out_valid,
  output logic [board_pkg::XLEN-1:0] out_data,
  output logic                       irq_pending,
  output logic                       halted
);
  import board_pkg::*;

  logic [XLEN-1:0] regs [NREGS];  // register file, x0 is writable
  logic [AW-1:0]   pc;
  logic [AW-1:0]   pc_next;
  logic [AW-1:0]   vector;
  logic [AW-1:0]   epc;
  logic [7:0]      rx_data;
  logic            rx_valid;
  logic            irr;
  logic            trap_req;
  logic            trap_take;
  logic            issue;
  logic            iret;
  logic            rd_we;
  logic            out_fire;
  logic            halt_fire;
  logic [XLEN-1:0] rs1_val;
  logic [XLEN-1:0] imm_ext;
  logic [XLEN-1:0] io_rdata;
  logic [XLEN-1:0] rd_val;
  intr_cmd_t       cmd;

  uart_rx u_uart_rx (
    .clk      (clk),
    .rst_n    (rst_n),
    .rx       (uart_rx),
    .rx_data  (rx_data),
    .rx_valid (rx_valid)
  );

  intr_ctrl u_intr_ctrl (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx_valid  (rx_valid),
    .cmd       (cmd),
    .trap_take (trap_take),
    .iret      (iret),
    .ret_pc    (pc),
    .irr       (irr),
    .trap_req  (trap_req),
    .vector    (vector),
    .epc       (epc)
  );

  // a pending trap replaces the fetched word for this cycle
  assign trap_take = run && trap_req;
  assign issue     = run && !trap_req;

  assign fetch_addr  = pc;
  assign irq_pending = irr;

  assign rs1_val = regs[instr.rs1];
  assign imm_ext = {{(XLEN - 12){instr.imm[11]}}, instr.imm};  // sign extend

  always_comb begin
    io_rdata = '0;
    if (instr.imm == 12'(IO_RX_DATA)) begin
      io_rdata = XLEN'(rx_data);
    end else if (instr.imm == 12'(IO_IRR)) begin
      io_rdata = XLEN'(irr);
    end
  end

  always_comb begin
    rd_we     = 1'b0;
    rd_val    = '0;
    pc_next   = pc + 1'b1;
    cmd       = '0;
    iret      = 1'b0;
    out_fire  = 1'b0;
    halt_fire = 1'b0;
    case (instr.opcode)
      OP_LI: begin
        rd_we  = 1'b1;
        rd_val = imm_ext;
      end
      OP_ADDI: begin
        rd_we  = 1'b1;
        rd_val = rs1_val + imm_ext;
      end
      OP_JMP:  pc_next = rs1_val[AW-1:0];
      OP_IN: begin
        rd_we  = 1'b1;
        rd_val = io_rdata;
      end
      OP_OUT:  out_fire = 1'b1;
      OP_INTR: begin
        cmd.valid = issue;
        cmd.sel   = intr_sel_e'(instr.imm[1:0]);
        cmd.value = rs1_val[AW-1:0];
      end
      OP_IRET: begin
        iret    = issue;
        pc_next = epc;
      end
      OP_HALT: begin
        halt_fire = 1'b1;
        pc_next   = pc;  // park on the halt word, only a trap moves pc
      end
      default: ;  // unused codes are no-ops
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc        <= '0;
      halted    <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      if (trap_take) pc <= vector;
      else if (issue) pc <= pc_next;

      if (issue && halt_fire) halted <= 1'b1;  // sticky until reset
      out_valid <= issue && out_fire;
    end
  end

  always_ff @(posedge clk) begin
    if (issue && rd_we) regs[instr.rd] <= rd_val;
    if (issue && out_fire) out_data <= rs1_val;
  end

endmodule

//--- verilog/intr_ctrl.sv
`timescale 1ns/1ps

module intr_ctrl (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     rx_valid,
  input  board_pkg::intr_cmd_t     cmd,
  input  logic                     trap_take,
  input  logic                     iret,
  input  logic [board_pkg::AW-1:0] ret_pc,
  output logic                     irr,
  output logic                     trap_req,
  output logic [board_pkg::AW-1:0] vector,
  output logic [board_pkg::AW-1:0] epc
);
  import board_pkg::*;

  logic ie;      // interrupt enable
  logic active;  // handler running
  logic ack;
  logic en_wr;
  logic vec_wr;

  assign ack    = cmd.valid && (cmd.sel == INTR_ACK) && cmd.value[0];
  assign en_wr  = cmd.valid && (cmd.sel == INTR_EN);
  assign vec_wr = cmd.valid && (cmd.sel == INTR_VEC);

  assign trap_req = irr && ie && !active;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      irr    <= 1'b0;
      ie     <= 1'b0;
      active <= 1'b0;
      vector <= '0;
    end else begin
      if (rx_valid) irr <= 1'b1;  // set beats clear
      else if (ack) irr <= 1'b0;

      // taking a trap drops the enable so a stale request cannot re-trap
      if (trap_take)  ie <= 1'b0;
      else if (en_wr) ie <= cmd.value[0];

      if (trap_take) active <= 1'b1;
      else if (iret) active <= 1'b0;

      if (vec_wr) vector <= cmd.value;
    end
  end

  always_ff @(posedge clk) begin
    if (trap_take) epc <= ret_pc;  // address of the skipped instruction
  end

endmodule

//--- verilog/mother_board.sv
`timescale 1ns/1ps

module mother_board (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       uart_rx,
  input  logic                       run,
  input  logic                       prog_we,
  input  logic [board_pkg::AW-1:0]   prog_addr,
  input  board_pkg::instr_t          prog_data,
  output logic                       out_valid,
  output logic [board_pkg::XLEN-1:0] out_data,
  output logic                       irq_pending,
  output logic                       halted
);
  import board_pkg::*;

  logic [AW-1:0] fetch_addr;
  instr_t        instr;

  cpu cpu (
    .clk         (clk),
    .rst_n       (rst_n),
    .run         (run),
    .uart_rx     (uart_rx),
    .fetch_addr  (fetch_addr),
    .instr       (instr),
    .out_valid   (out_valid),
    .out_data    (out_data),
    .irq_pending (irq_pending),
    .halted      (halted)
  );

  rom rom (
    .clk        (clk),
    .prog_we    (prog_we),
    .prog_addr  (prog_addr),
    .prog_data  (prog_data),
    .fetch_addr (fetch_addr),
    .instr      (instr)
  );

endmodule

//--- verilog/rom.sv
`timescale 1ns/1ps

module rom (
  input  logic                     clk,
  input  logic                     prog_we,
  input  logic [board_pkg::AW-1:0] prog_addr,
  input  board_pkg::instr_t        prog_data,
  input  logic [board_pkg::AW-1:0] fetch_addr,
  output board_pkg::instr_t        instr
);
  import board_pkg::*;

  instr_t mem [ROM_DEPTH];

  always_ff @(posedge clk) begin
    if (prog_we) mem[prog_addr] <= prog_data;  // load port
  end

  assign instr = mem[fetch_addr];  // async fetch

endmodule

//--- verilog/uart_rx.sv
`timescale 1ns/1ps

module uart_rx (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       rx,
  output logic [7:0] rx_data,
  output logic       rx_valid
);
  import board_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_START,
    ST_DATA,
    ST_STOP
  } state_e;

  state_e             state;
  logic [1:0]         rx_sync;  // two flop synchronizer
  logic               rx_prev;
  logic               rx_s;
  logic [BAUD_CW-1:0] baud_cnt;
  logic [2:0]         bit_cnt;
  logic [7:0]         shift;
  logic               baud_mid;
  logic               baud_end;

  assign rx_s     = rx_sync[1];
  assign baud_mid = (baud_cnt == BAUD_CW'(BAUD_DIV / 2 - 1));
  assign baud_end = (baud_cnt == BAUD_CW'(BAUD_DIV - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_sync <= 2'b11;  // line idles high
      rx_prev <= 1'b1;
    end else begin
      rx_sync <= {rx_sync[0], rx};
      rx_prev <= rx_s;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= ST_IDLE;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      case (state)
        ST_IDLE: begin
          baud_cnt <= '0;
          if (rx_prev && !rx_s) state <= ST_START;  // falling edge only
        end
        ST_START: begin
          if (baud_mid) begin
            baud_cnt <= '0;
            bit_cnt  <= '0;
            state    <= rx_s ? ST_IDLE : ST_DATA;  // glitch rejected
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
        ST_DATA: begin
          if (baud_end) begin
            baud_cnt <= '0;
            bit_cnt  <= bit_cnt + 1'b1;
            if (bit_cnt == 3'd7) state <= ST_STOP;
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
        ST_STOP: begin
          if (baud_end) begin
            state    <= ST_IDLE;
            rx_valid <= rx_s;  // bad stop bit drops the byte
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == ST_DATA && baud_end) shift <= {rx_s, shift[7:1]};  // lsb first
    if (state == ST_STOP && baud_end && rx_s) rx_data <= shift;
  end

endmodule
